// ==== hw/mg_params.svh ====
// memory game parameters
`ifndef MG_PARAMS_SVH
`define MG_PARAMS_SVH

// board layout, three rows of six
`define MG_CARD_COUNT 18

// every card has exactly one partner
`define MG_PAIR_COUNT 9

// round length, seconds
`define MG_ROUND_SECONDS 60

// 50 MHz board clock
`define MG_TICKS_PER_SECOND 50000000

`endif

// ==== hw/mg_pkg.sv ====
// memory game shared types
`default_nettype none

`include "mg_params.svh"

package mg_pkg;

	// one bit per card switch
	typedef logic [`MG_CARD_COUNT-1:0] card_mask_t;

	// single BCD digit, scores never pass 9
	typedef logic [3:0] score_t;

	// tens in [7:4], ones in [3:0]
	typedef logic [7:0] seconds_t;

	typedef enum logic
	{
		player_one = 1'b0,
		player_two = 1'b1
	} player_t;

	// active low, segment g in bit 6
	typedef logic [6:0] seg_t;

endpackage

`default_nettype wire

// ==== hw/turn_sequencer.sv ====
// card pick sequencer
`timescale 1ns/1ps
`default_nettype none

module turn_sequencer
(
	input  wire logic               clock,
	input  wire logic               reset_n,
	input  wire logic               pick_button,   // clean, high while pressed
	input  wire mg_pkg::card_mask_t card_switches,
	output logic                    pick_valid,
	output mg_pkg::card_mask_t      first_pick,
	output mg_pkg::card_mask_t      second_pick
);

	typedef enum logic [2:0]
	{
		choose_first,
		first_wait,
		choose_second,
		second_wait,
		check_pair,
		check_wait
	} turn_state_t;

	turn_state_t state;
	turn_state_t state_next;

	// each step is a press then a release
	always_comb
	begin
		state_next = state;
		case (state)
			choose_first:  if (pick_button) state_next = first_wait;
			first_wait:    if (!pick_button) state_next = choose_second; // first card taken
			choose_second: if (pick_button) state_next = second_wait;
			second_wait:   if (!pick_button) state_next = check_pair; // second card taken
			check_pair:    if (pick_button) state_next = check_wait; // player acknowledges
			check_wait:    if (!pick_button) state_next = choose_first;
			default:       state_next = choose_first;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			state <= choose_first;
			pick_valid <= 1'b0;
		end
		else
		begin
			state <= state_next;
			pick_valid <= (state == second_wait) && !pick_button; // one cycle, entering check
		end
	end

	// masks sampled on the release edge
	always_ff @(posedge clock)
	begin
		if (state == first_wait && !pick_button)
			first_pick <= card_switches;
		if (state == second_wait && !pick_button)
			second_pick <= card_switches;
	end

	// strobe must come from a single release, never held
	assert property (@(posedge clock) disable iff (!reset_n)
		pick_valid |=> !pick_valid);

endmodule

`default_nettype wire

// ==== hw/pair_judge.sv ====
// pair judge with scores and turn
`timescale 1ns/1ps
`default_nettype none

`include "mg_params.svh"

module pair_judge
(
	input  wire logic               clock,
	input  wire logic               reset_n,
	input  wire logic               pick_valid,
	input  wire mg_pkg::card_mask_t first_pick,
	input  wire mg_pkg::card_mask_t second_pick,
	input  wire logic               time_up,
	output mg_pkg::player_t         current_player,
	output logic                    game_over,
	output mg_pkg::score_t          score_one,
	output mg_pkg::score_t          score_two
);

	// partner card of each card index, fixed deal
	localparam int unsigned partner_of [`MG_CARD_COUNT] =
		'{16, 6, 13, 14, 15, 8, 1, 9, 5, 7, 17, 12, 11, 2, 3, 4, 0, 10};

	mg_pkg::card_mask_t claimed;        // cards already taken off the board
	mg_pkg::card_mask_t partner_mask;   // partner of the first pick
	logic [3:0]         pairs_claimed;
	logic               single_picks;
	logic               unclaimed;
	logic               is_match;

	always_comb
	begin
		partner_mask = '0;
		for (int i = 0; i < `MG_CARD_COUNT; i++)
		begin
			if (first_pick[i])
				partner_mask[partner_of[i]] = 1'b1;
		end
		single_picks = $onehot(first_pick) && $onehot(second_pick); // one switch per pick
		unclaimed = ((first_pick | second_pick) & claimed) == '0;
		is_match = single_picks && (partner_mask == second_pick) && unclaimed;
	end

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			claimed <= '0;
			pairs_claimed <= '0;
			score_one <= '0;
			score_two <= '0;
			current_player <= mg_pkg::player_one;
			game_over <= 1'b0;
		end
		else
		begin
			if (time_up)
				game_over <= 1'b1; // clock ran out
			if (pick_valid && !game_over)
			begin
				if (is_match)
				begin
					claimed <= claimed | first_pick | second_pick;
					pairs_claimed <= pairs_claimed + 4'd1;
					if (current_player == mg_pkg::player_one)
						score_one <= score_one + 4'd1;
					else
						score_two <= score_two + 4'd1;
					if (pairs_claimed == 4'(`MG_PAIR_COUNT - 1))
						game_over <= 1'b1; // last pair off the board
				end
				else
				begin
					// miss or repeat, other player's turn
					current_player <= (current_player == mg_pkg::player_one) ?
						mg_pkg::player_two : mg_pkg::player_one;
				end
			end
		end
	end

	// claimed cards stay claimed until reset
	assert property (@(posedge clock) disable iff (!reset_n)
		$past(reset_n) |-> ((claimed & $past(claimed)) == $past(claimed)));

endmodule

`default_nettype wire

// ==== hw/round_timer.sv ====
// round countdown timer
`timescale 1ns/1ps
`default_nettype none

`include "mg_params.svh"

module round_timer
#(
	parameter int ticks_per_second = `MG_TICKS_PER_SECOND
)
(
	input  wire logic        clock,
	input  wire logic        reset_n,
	input  wire logic        game_over,
	output mg_pkg::seconds_t seconds_left,
	output logic             time_up
);

	localparam int tick_width = $clog2(ticks_per_second + 1);
	localparam mg_pkg::seconds_t start_seconds =
		{4'(`MG_ROUND_SECONDS / 10), 4'(`MG_ROUND_SECONDS % 10)};

	logic [tick_width-1:0] tick_count; // rate divider, counts down
	logic                  running;
	logic                  second_tick;

	assign time_up = (seconds_left == '0);
	assign running = !game_over && !time_up; // frozen at 00 or once the game ends
	assign second_tick = running && (tick_count == '0);

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			tick_count <= tick_width'(ticks_per_second - 1);
			seconds_left <= start_seconds;
		end
		else if (running)
		begin
			if (second_tick)
			begin
				tick_count <= tick_width'(ticks_per_second - 1); // reload
				if (seconds_left[3:0] == 4'd0)
					seconds_left <= {seconds_left[7:4] - 4'd1, 4'd9}; // borrow from tens
				else
					seconds_left <= seconds_left - 8'd1;
			end
			else
				tick_count <= tick_count - 1'b1;
		end
	end

	assert property (@(posedge clock) disable iff (!reset_n)
		(seconds_left[3:0] <= 4'd9) && (seconds_left[7:4] <= 4'd9));

endmodule

`default_nettype wire

// ==== hw/score_display.sv ====
// seven-segment score display
`timescale 1ns/1ps
`default_nettype none

module score_display
(
	input  wire mg_pkg::score_t   score_one,
	input  wire mg_pkg::score_t   score_two,
	input  wire mg_pkg::seconds_t seconds_left,
	output mg_pkg::seg_t          hex_score_one,
	output mg_pkg::seg_t          hex_score_two,
	output mg_pkg::seg_t          hex_seconds_ones,
	output mg_pkg::seg_t          hex_seconds_tens,
	output mg_pkg::seg_t          hex_lead
);

	logic [3:0] lead; // 1 or 2 for the leader, 0 on a tie

	// one table for every digit, active low
	function automatic mg_pkg::seg_t seg_of(input logic [3:0] digit);
		case (digit)
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0011000;
			default: return 7'b0001100; // P, never a valid BCD digit
		endcase
	endfunction

	always_comb
	begin
		if (score_one > score_two)
			lead = 4'd1;
		else if (score_two > score_one)
			lead = 4'd2;
		else
			lead = 4'd0;
	end

	assign hex_score_one = seg_of(score_one);
	assign hex_score_two = seg_of(score_two);
	assign hex_seconds_ones = seg_of(seconds_left[3:0]);
	assign hex_seconds_tens = seg_of(seconds_left[7:4]);
	assign hex_lead = seg_of(lead);

endmodule

`default_nettype wire

// ==== hw/memory_game.sv ====
// memory game top level
`timescale 1ns/1ps
`default_nettype none

`include "mg_params.svh"

module memory_game
#(
	parameter int ticks_per_second = `MG_TICKS_PER_SECOND
)
(
	input  wire logic               clock,
	input  wire logic               reset_n,
	input  wire logic               pick_button,
	input  wire mg_pkg::card_mask_t card_switches,
	output mg_pkg::player_t         current_player,
	output logic                    game_over,
	output mg_pkg::seg_t            hex_score_one,
	output mg_pkg::seg_t            hex_score_two,
	output mg_pkg::seg_t            hex_seconds_ones,
	output mg_pkg::seg_t            hex_seconds_tens,
	output mg_pkg::seg_t            hex_lead
);

	logic               pick_valid;
	mg_pkg::card_mask_t first_pick;
	mg_pkg::card_mask_t second_pick;
	mg_pkg::score_t     score_one;
	mg_pkg::score_t     score_two;
	mg_pkg::seconds_t   seconds_left;
	logic               time_up;

	turn_sequencer u_turn_sequencer
	(
		.clock         (clock),
		.reset_n       (reset_n),
		.pick_button   (pick_button),
		.card_switches (card_switches),
		.pick_valid    (pick_valid),
		.first_pick    (first_pick),
		.second_pick   (second_pick)
	);

	pair_judge u_pair_judge
	(
		.clock          (clock),
		.reset_n        (reset_n),
		.pick_valid     (pick_valid),
		.first_pick     (first_pick),
		.second_pick    (second_pick),
		.time_up        (time_up),
		.current_player (current_player),
		.game_over      (game_over),
		.score_one      (score_one),
		.score_two      (score_two)
	);

	round_timer #(.ticks_per_second(ticks_per_second)) u_round_timer
	(
		.clock        (clock),
		.reset_n      (reset_n),
		.game_over    (game_over),
		.seconds_left (seconds_left),
		.time_up      (time_up)
	);

	score_display u_score_display
	(
		.score_one        (score_one),
		.score_two        (score_two),
		.seconds_left     (seconds_left),
		.hex_score_one    (hex_score_one),
		.hex_score_two    (hex_score_two),
		.hex_seconds_ones (hex_seconds_ones),
		.hex_seconds_tens (hex_seconds_tens),
		.hex_lead         (hex_lead)
	);

endmodule

`default_nettype wire

// ==== test/memory_game_tb.sv ====
// memory game testbench
`timescale 1ns/1ps
`default_nettype none

`include "mg_params.svh"

module memory_game_tb;

	logic               clock;
	logic               reset_n;
	logic               pick_button;
	mg_pkg::card_mask_t card_switches;
	mg_pkg::player_t    current_player;
	logic               game_over;
	mg_pkg::seg_t       hex_score_one;
	mg_pkg::seg_t       hex_score_two;
	mg_pkg::seg_t       hex_seconds_ones;
	mg_pkg::seg_t       hex_seconds_tens;
	mg_pkg::seg_t       hex_lead;

	localparam int pair_lo [`MG_PAIR_COUNT] = '{10, 0, 4, 3, 2, 11, 7, 5, 1}; // dealt pairs
	localparam int pair_hi [`MG_PAIR_COUNT] = '{17, 16, 15, 14, 13, 12, 9, 8, 6};

	int errors;
	int timeouts;
	int exp_one;     // expected scores and turn
	int exp_two;
	int exp_player;
	int card_a;
	int card_b;
	int held_ones;
	int held_tens;
	int n;

	memory_game #(.ticks_per_second(4)) u_dut
	(
		.clock            (clock),
		.reset_n          (reset_n),
		.pick_button      (pick_button),
		.card_switches    (card_switches),
		.current_player   (current_player),
		.game_over        (game_over),
		.hex_score_one    (hex_score_one),
		.hex_score_two    (hex_score_two),
		.hex_seconds_ones (hex_seconds_ones),
		.hex_seconds_tens (hex_seconds_tens),
		.hex_lead         (hex_lead)
	);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock; // 100 ns period
	end

	// active-low digit patterns with g in bit 6
	function automatic int seg_pattern(input int digit);
		case (digit)
			0: return 7'b1000000;
			1: return 7'b1111001;
			2: return 7'b0100100;
			3: return 7'b0110000;
			4: return 7'b0011001;
			5: return 7'b0010010;
			6: return 7'b0000010;
			7: return 7'b1111000;
			8: return 7'b0000000;
			default: return 7'b0011000;
		endcase
	endfunction

	function automatic int partner_card(input int card);
		int found;
		found = 0;
		for (int i = 0; i < `MG_PAIR_COUNT; i++)
		begin
			if (pair_lo[i] == card)
				found = pair_hi[i];
			if (pair_hi[i] == card)
				found = pair_lo[i];
		end
		return found;
	endfunction

	function automatic mg_pkg::card_mask_t card_bit(input int card);
		return mg_pkg::card_mask_t'(1) << card;
	endfunction

	task automatic next_cycle;
		@(posedge clock);
		#5; // drive and sample just after the edge
	endtask

	task automatic apply_reset;
		reset_n = 1'b0;
		repeat (8) next_cycle;
		reset_n = 1'b1;
		exp_one = 0;
		exp_two = 0;
		exp_player = 0;
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		assert (actual == expected)
		else
		begin
			errors++;
			$display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	// scores, lead, turn and end flag against the model
	task automatic check_board(input string name, input int over);
		int lead;
		lead = (exp_one > exp_two) ? 1 : ((exp_two > exp_one) ? 2 : 0);
		check_value({name, " score one"}, seg_pattern(exp_one), hex_score_one);
		check_value({name, " score two"}, seg_pattern(exp_two), hex_score_two);
		check_value({name, " lead"}, seg_pattern(lead), hex_lead);
		check_value({name, " player"}, exp_player, current_player);
		check_value({name, " game over"}, over, game_over);
	endtask

	task automatic press_release(input mg_pkg::card_mask_t mask);
		card_switches = mask;
		pick_button = 1'b1;
		next_cycle;
		pick_button = 0;
		next_cycle;
	endtask

	task automatic play_turn(input mg_pkg::card_mask_t first, input mg_pkg::card_mask_t second);
		int k;
		press_release(first);
		press_release(second);
		k = 0;
		while (!u_dut.pick_valid && k < 10)
		begin
			next_cycle;
			k++;
		end
		if (!u_dut.pick_valid)
		begin
			timeouts++;
			$display("timeout: the pick strobe never came");
		end
		next_cycle; // judge result lands here
		press_release('0); // acknowledge and go back to first pick
	endtask

	// model of the turn rule
	task automatic expect_turn(input int match);
		if (match && exp_player == 0)
			exp_one++;
		else if (match)
			exp_two++;
		else
			exp_player = 1 - exp_player;
	endtask

	initial
	begin
		errors = 0;
		timeouts = 0;
		void'($urandom(58788)); // seed once for the run
		pick_button = 1'b0;
		card_switches = '0;
		reset_n = 1'b0;
		apply_reset;
		check_board("reset", 0);
		check_value("reset tens", seg_pattern(6), hex_seconds_tens);
		check_value("reset ones", seg_pattern(0), hex_seconds_ones);

		play_turn(card_bit(17), card_bit(10));
		expect_turn(1);
		check_board("first match", 0);

		card_a = int'($urandom % 18);
		card_b = (partner_card(card_a) + 1 + int'($urandom % 17)) % 18; // never the partner
		play_turn(card_bit(card_a), card_bit(card_b));
		expect_turn(0);
		check_board("random miss", 0);
		play_turn(card_bit(16), card_bit(0));
		expect_turn(1);
		check_board("second match", 0);

		play_turn(card_bit(17), card_bit(10)); // already on the claimed list
		expect_turn(0);
		check_board("claimed pair", 0);
		play_turn(card_bit(15) | card_bit(3), card_bit(4) | card_bit(14)); // partners bit for bit
		expect_turn(0);
		check_board("two switches", 0);

		for (int i = 2; i < `MG_PAIR_COUNT; i++)
		begin
			play_turn(card_bit(pair_lo[i]), card_bit(pair_hi[i]));
			expect_turn(1);
		end
		check_board("all pairs", 1);
		play_turn(card_bit(6), card_bit(1));
		check_board("pick after end", 1);
		held_ones = hex_seconds_ones;
		held_tens = hex_seconds_tens;
		repeat (12) next_cycle; // three timer periods
		check_value("frozen ones", held_ones, hex_seconds_ones);
		check_value("frozen tens", held_tens, hex_seconds_tens);

		apply_reset;
		check_value("fresh tens", seg_pattern(6), hex_seconds_tens);
		n = 0;
		while (!game_over && n < 400)
		begin
			next_cycle;
			n++;
		end
		if (!game_over)
		begin
			timeouts++;
			$display("timeout: the round timer never ended the game");
		end
		check_value("time up tens", seg_pattern(0), hex_seconds_tens);
		check_value("time up ones", seg_pattern(0), hex_seconds_ones);
		play_turn(card_bit(17), card_bit(10));
		check_board("pick after time up", 1);

		$display("errors %0d, timeouts %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hw
hw/mg_pkg.sv
hw/turn_sequencer.sv
hw/pair_judge.sv
hw/round_timer.sv
hw/score_display.sv
hw/memory_game.sv
test/memory_game_tb.sv

// ==== Makefile ====
LOG = sim.log
BIN = obj_dir/memory_game_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module memory_game_tb -Mdir obj_dir -o memory_game_tb

run: compile
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Something failed" $(LOG); then exit 1; fi
	@if ! grep -q "Everything OK" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
